// ==== logic/mem_pkg.sv ====
////////////////////////////////////////
// widths and request codes shared by the memory controller blocks
// and the testbench, named through mem_pkg:: scope
////////////////////////////////////////

package mem_pkg;

    // full address carried on the bus; the RAM decodes only the low bits
    localparam int addr_w = 32;

    // client data word
    localparam int data_w = 32;

    // external byte bus
    localparam int byte_w = 8;

    // access length, byte count minus one
    typedef enum logic [1:0] {
        len_byte = 2'd0,
        len_half = 2'd1,
        len_word = 2'd3
    } len_t;

    // which client owns the access in flight
    typedef enum logic {
        client_fetch = 1'b0,
        client_data  = 1'b1
    } client_t;

endpackage

// ==== logic/io_map_pkg.sv ====
////////////////////////////////////////
// memory-mapped I/O locations seen on the byte bus
////////////////////////////////////////

package io_map_pkg;

    // address bits that select the I/O region
    localparam int io_sel_hi = 17;
    localparam int io_sel_lo = 16;

    // value of those bits inside the I/O region
    localparam logic [1:0] io_region = 2'b11;

    // write sends a byte out, read takes an input byte
    localparam logic [31:0] io_uart_addr = 32'h0003_0000;

    // read returns the clock count
    localparam logic [31:0] io_clock_addr = 32'h0003_0004;

endpackage

// ==== logic/mem_arbiter.sv ====
////////////////////////////////////////
// picks the next owner of the byte bus and steers completion back
////////////////////////////////////////
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rdy,
    // instruction fetch client
    input  logic                       fetch_en,
    input  logic [mem_pkg::addr_w-1:0] fetch_addr,
    output logic                       fetch_done,
    output logic [mem_pkg::data_w-1:0] fetch_inst,
    // data cache client
    input  logic                       data_en,
    input  logic                       data_wr,
    input  mem_pkg::len_t              data_len,
    input  logic [mem_pkg::addr_w-1:0] data_addr,
    input  logic [mem_pkg::data_w-1:0] data_wdata,
    output logic                       data_done,
    output logic [mem_pkg::data_w-1:0] data_rdata,
    // to the byte sequencer
    input  logic                       busy,
    output logic                       start,
    output mem_pkg::client_t           owner,
    output logic [mem_pkg::addr_w-1:0] acc_addr,
    output logic                       acc_wr,
    output mem_pkg::len_t              acc_len,
    output logic [mem_pkg::data_w-1:0] acc_wdata,
    input  logic                       fin,
    input  mem_pkg::client_t           fin_owner,
    input  logic [mem_pkg::data_w-1:0] fin_rdata
);

    logic fetch_granted;
    logic data_granted;
    logic free;
    logic pick_data;
    logic pick_fetch;

    // no new grant while a start is still waiting to be taken
    assign free = !busy && !start;

    // data first since it belongs to the older instruction
    assign pick_data  = free && data_en && !data_granted;
    assign pick_fetch = free && fetch_en && !fetch_granted && !pick_data;

    // done only counts on a running cycle
    assign fetch_done = fin && rdy && (fin_owner == mem_pkg::client_fetch);
    assign data_done  = fin && rdy && (fin_owner == mem_pkg::client_data);
    assign fetch_inst = fin_rdata;
    assign data_rdata = fin_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            start         <= 1'b0;
            fetch_granted <= 1'b0;
            data_granted  <= 1'b0;
        end else if (rdy) begin
            start <= pick_data || pick_fetch;
            // held en is ignored until its done
            if (pick_fetch) begin
                fetch_granted <= 1'b1;
            end else if (fetch_done) begin
                fetch_granted <= 1'b0;
            end
            if (pick_data) begin
                data_granted <= 1'b1;
            end else if (data_done) begin
                data_granted <= 1'b0;
            end
        end
    end

    // request fields of the winner
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (pick_data) begin
                owner     <= mem_pkg::client_data;
                acc_addr  <= data_addr;
                acc_wr    <= data_wr;
                acc_len   <= data_len;
                acc_wdata <= data_wdata;
            end else if (pick_fetch) begin
                owner     <= mem_pkg::client_fetch;
                acc_addr  <= fetch_addr;
                acc_wr    <= 1'b0;
                acc_len   <= mem_pkg::len_word;
                acc_wdata <= '0;
            end
        end
    end

endmodule

// ==== logic/byte_sequencer.sv ====
////////////////////////////////////////
// runs one granted access as byte cycles on the external bus
// and assembles read data little-endian
////////////////////////////////////////
`timescale 1ns/1ps

module byte_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rdy,
    // granted access
    input  logic                       start,
    input  mem_pkg::client_t           owner,
    input  logic [mem_pkg::addr_w-1:0] acc_addr,
    input  logic                       acc_wr,
    input  mem_pkg::len_t              acc_len,
    input  logic [mem_pkg::data_w-1:0] acc_wdata,
    output logic                       busy,
    output logic                       fin,
    output mem_pkg::client_t           fin_owner,
    output logic [mem_pkg::data_w-1:0] rdata,
    // external byte bus
    input  logic                       io_buffer_full,
    input  logic [mem_pkg::byte_w-1:0] mem_din,
    output logic [mem_pkg::byte_w-1:0] mem_dout,
    output logic [mem_pkg::addr_w-1:0] mem_a,
    output logic                       mem_wr
);

    logic                       issuing;
    logic                       wr_reg;
    logic [1:0]                 cnt;
    logic [1:0]                 cnt_nxt;
    mem_pkg::len_t              len_q;
    logic [mem_pkg::addr_w-1:0] base_q;
    logic [mem_pkg::data_w-1:0] wdata_q;
    logic                       accept;
    logic                       last;
    logic                       uart_hit;
    logic                       stall;
    logic                       tag_vld;
    logic [1:0]                 tag_lane;

    assign accept  = start && !busy;
    assign last    = (cnt == len_q);
    assign cnt_nxt = cnt + 2'd1;

    // the bus decodes bits 17:0 only
    assign uart_hit =
        (mem_a[io_map_pkg::io_sel_hi:io_map_pkg::io_sel_lo] == io_map_pkg::io_region) &&
        (mem_a[io_map_pkg::io_sel_lo-1:0] == io_map_pkg::io_uart_addr[io_map_pkg::io_sel_lo-1:0]);

    // UART byte waits on the bus until the buffer drains
    assign stall = wr_reg && uart_hit && io_buffer_full;

    // no write strobe on a frozen or stalled cycle
    assign mem_wr = wr_reg && rdy && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            issuing <= 1'b0;
            wr_reg  <= 1'b0;
            fin     <= 1'b0;
            cnt     <= 2'd0;
            mem_a   <= '0;
        end else if (rdy) begin
            fin <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                issuing <= 1'b1;
                wr_reg  <= acc_wr;
                cnt     <= 2'd0;
                mem_a   <= acc_addr;
            end else if (issuing && !stall) begin
                if (last) begin
                    issuing <= 1'b0;
                    wr_reg  <= 1'b0;
                    // park away from I/O so no input byte is consumed
                    mem_a   <= '0;
                    // writes end here, reads still wait for the last byte
                    if (wr_reg) begin
                        busy <= 1'b0;
                        fin  <= 1'b1;
                    end
                end else begin
                    cnt   <= cnt_nxt;
                    mem_a <= base_q + mem_pkg::addr_w'(cnt_nxt);
                end
            end else if (busy && !issuing) begin
                // last read byte is in rdata now
                busy <= 1'b0;
                fin  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (accept) begin
                fin_owner <= owner;
                len_q     <= acc_len;
                base_q    <= acc_addr;
                wdata_q   <= acc_wdata;
                mem_dout  <= acc_wdata[mem_pkg::byte_w-1:0];
            end else if (issuing && !stall && !last) begin
                mem_dout <= wdata_q[cnt_nxt*mem_pkg::byte_w +: mem_pkg::byte_w];
            end
        end
    end

    // The RAM answers every cycle, frozen or not, so the lane of the
    // byte now on mem_din is tracked outside the rdy freeze. A lane held
    // on the bus over a frozen cycle is simply captured twice.
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_vld <= 1'b0;
        end else begin
            tag_vld <= issuing && !wr_reg;
        end
    end

    always_ff @(posedge clk) begin
        tag_lane <= cnt;
        // upper bytes of short loads stay zero
        if (accept) begin
            rdata <= '0;
        end else if (tag_vld) begin
            rdata[tag_lane*mem_pkg::byte_w +: mem_pkg::byte_w] <= mem_din;
        end
    end

endmodule

// ==== logic/memctrl.sv ====
////////////////////////////////////////
// memory controller top, joins two clients to the byte bus
////////////////////////////////////////
`timescale 1ns/1ps

module memctrl (
    input  logic                       clk_in,
    input  logic                       rst,
    input  logic                       rdy,
    // instruction fetch client
    input  logic                       fetch_en,
    input  logic [mem_pkg::addr_w-1:0] fetch_addr,
    output logic                       fetch_done,
    output logic [mem_pkg::data_w-1:0] fetch_inst,
    // data cache client
    input  logic                       data_en,
    input  logic                       data_wr,
    input  mem_pkg::len_t              data_len,
    input  logic [mem_pkg::addr_w-1:0] data_addr,
    input  logic [mem_pkg::data_w-1:0] data_wdata,
    output logic                       data_done,
    output logic [mem_pkg::data_w-1:0] data_rdata,
    // external byte bus
    input  logic [mem_pkg::byte_w-1:0] mem_din,
    output logic [mem_pkg::byte_w-1:0] mem_dout,
    output logic [mem_pkg::addr_w-1:0] mem_a,
    output logic                       mem_wr,
    // high while the UART cannot take a byte
    input  logic                       io_buffer_full
);

    logic                       busy;
    logic                       start;
    mem_pkg::client_t           owner;
    logic [mem_pkg::addr_w-1:0] acc_addr;
    logic                       acc_wr;
    mem_pkg::len_t              acc_len;
    logic [mem_pkg::data_w-1:0] acc_wdata;
    logic                       fin;
    mem_pkg::client_t           fin_owner;
    logic [mem_pkg::data_w-1:0] fin_rdata;

    mem_arbiter u_arbiter (
        .clk        (clk_in),
        .rst        (rst),
        .rdy        (rdy),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .fetch_inst (fetch_inst),
        .data_en    (data_en),
        .data_wr    (data_wr),
        .data_len   (data_len),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_done  (data_done),
        .data_rdata (data_rdata),
        .busy       (busy),
        .start      (start),
        .owner      (owner),
        .acc_addr   (acc_addr),
        .acc_wr     (acc_wr),
        .acc_len    (acc_len),
        .acc_wdata  (acc_wdata),
        .fin        (fin),
        .fin_owner  (fin_owner),
        .fin_rdata  (fin_rdata)
    );

    byte_sequencer u_sequencer (
        .clk            (clk_in),
        .rst            (rst),
        .rdy            (rdy),
        .start          (start),
        .owner          (owner),
        .acc_addr       (acc_addr),
        .acc_wr         (acc_wr),
        .acc_len        (acc_len),
        .acc_wdata      (acc_wdata),
        .busy           (busy),
        .fin            (fin),
        .fin_owner      (fin_owner),
        .rdata          (fin_rdata),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr)
    );

endmodule

// ==== tb/tb_ram.sv ====
////////////////////////////////////////
// byte RAM on the external bus for the testbench, with a UART
// capture queue and a clock counter in the I/O region
////////////////////////////////////////
`timescale 1ns/1ps

module tb_ram (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_a,
    input  logic [7:0]  mem_dout,
    input  logic        mem_wr,
    output logic [7:0]  mem_din
);

    localparam int ram_bytes = 1 << 17;

    logic [7:0]  mem [0:ram_bytes-1];
    // bytes written to the UART, oldest first
    logic [7:0]  uart_q [$];
    logic [31:0] clock_count;
    logic        io_hit;

    assign io_hit =
        (mem_a[io_map_pkg::io_sel_hi:io_map_pkg::io_sel_lo] == io_map_pkg::io_region);

    // random contents filled once the testbench has seeded $urandom
    initial begin
        #1;
        for (int i = 0; i < ram_bytes; i++) begin
            mem[17'(i)] = 8'($urandom);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            clock_count <= '0;
        end else begin
            clock_count <= clock_count + 32'd1;
        end
    end

    // one cycle of read latency
    always @(posedge clk) begin
        if (io_hit) begin
            if (mem_a[31:2] == io_map_pkg::io_clock_addr[31:2]) begin
                mem_din <= 8'(clock_count >> (8 * mem_a[1:0]));
            end else begin
                // no input bytes pending on the UART
                mem_din <= 8'h00;
            end
            if (mem_wr && mem_a == io_map_pkg::io_uart_addr) begin
                uart_q.push_back(mem_dout);
            end
        end else begin
            mem_din <= mem[mem_a[16:0]];
            if (mem_wr) begin
                mem[mem_a[16:0]] = mem_dout;
            end
        end
    end

endmodule

// ==== tb/tb_memctrl.sv ====
////////////////////////////////////////
// testbench for memctrl: random client traffic on a byte RAM,
// checked against a byte model of memory
////////////////////////////////////////
`timescale 1ns/1ps

module tb_memctrl;

    // about 4x the worst case of all tests together
    localparam int max_cycles    = 20000;
    // longest single access with rdy and UART stalls included
    localparam int access_limit  = 200;
    localparam int fetch_latency = 7;
    localparam int ram_bytes     = 1 << 17;

    logic          clk;
    logic          rst;
    logic          rdy;
    logic          fetch_en;
    logic [31:0]   fetch_addr;
    logic          fetch_done;
    logic [31:0]   fetch_inst;
    logic          data_en;
    logic          data_wr;
    mem_pkg::len_t data_len;
    logic [31:0]   data_addr;
    logic [31:0]   data_wdata;
    logic          data_done;
    logic [31:0]   data_rdata;
    logic [7:0]    mem_din;
    logic [7:0]    mem_dout;
    logic [31:0]   mem_a;
    logic          mem_wr;
    logic          io_buffer_full;

    logic [7:0] model [0:ram_bytes-1];
    logic [7:0] uart_expect [$];
    bit         rdy_random;
    bit         full_random;
    int         checks        = 0;
    int         errors        = 0;
    int         bus_errors    = 0;
    int         frozen_cycles = 0;
    int         uart_waits    = 0;
    int         cycles        = 0;

    memctrl DUT (
        .clk_in (clk),
        .*
    );

    tb_ram u_ram (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // bus rules that hold on every cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (!rdy) begin
                frozen_cycles++;
            end
            if (io_buffer_full && mem_a == io_map_pkg::io_uart_addr) begin
                uart_waits++;
            end
            if (mem_wr && !rdy) begin
                $display("mem_wr is high during a frozen cycle at address %h", mem_a);
                bus_errors++;
            end
            if (mem_wr && io_buffer_full && mem_a == io_map_pkg::io_uart_addr) begin
                $display("UART write issued while io_buffer_full is high");
                bus_errors++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (rdy_random) begin
            rdy = ($urandom % 4) != 0;
        end else begin
            rdy = 1'b1;
        end
        if (full_random) begin
            io_buffer_full = ($urandom % 2) == 1;
        end else begin
            io_buffer_full = 1'b0;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %s finished, %0d errors", name, errors + bus_errors - err_start);
    endtask

    // little-endian bytes from the model, zero-extended
    function automatic logic [31:0] model_read(input logic [31:0] addr, input int nbytes);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < nbytes; k++) begin
            word[8*k +: 8] = model[17'(addr + 32'(k))];
        end
        return word;
    endfunction

    task automatic model_write(input logic [31:0] addr, input int nbytes,
                               input logic [31:0] wdata);
        for (int k = 0; k < nbytes; k++) begin
            model[17'(addr + 32'(k))] = wdata[8*k +: 8];
        end
    endtask

    function automatic mem_pkg::len_t pick_len();
        case ($urandom % 3)
            0:       return mem_pkg::len_byte;
            1:       return mem_pkg::len_half;
            default: return mem_pkg::len_word;
        endcase
    endfunction

    // half the accesses go to a small window so loads see earlier stores
    function automatic logic [31:0] pick_addr(input mem_pkg::len_t len);
        logic [31:0] a;
        if (($urandom % 2) == 1) begin
            a = 32'h0001_f000 | ($urandom & 32'h0000_003f);
        end else begin
            a = $urandom & 32'h0001_ffff;
        end
        if (len == mem_pkg::len_half) begin
            a[0] = 1'b0;
        end else if (len == mem_pkg::len_word) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    // one fetch, one data access, or both raised in the same cycle
    task automatic run_access(
        input  bit            use_fetch,
        input  logic [31:0]   f_addr,
        input  bit            use_data,
        input  logic          wr,
        input  mem_pkg::len_t len,
        input  logic [31:0]   addr,
        input  logic [31:0]   wdata,
        output int            f_cycles,
        output int            d_cycles
    );
        logic [31:0] f_expect;
        logic [31:0] d_expect;
        int          nbytes;
        int          waited;
        nbytes   = int'(len) + 1;
        f_expect = model_read(f_addr, 4);
        d_expect = model_read(addr, nbytes);
        f_cycles = -1;
        d_cycles = -1;
        waited   = 0;
        next_cycle();
        fetch_en   = use_fetch;
        fetch_addr = f_addr;
        data_en    = use_data;
        data_wr    = wr;
        data_len   = len;
        data_addr  = addr;
        data_wdata = wdata;
        while (((use_fetch && f_cycles < 0) || (use_data && d_cycles < 0)) &&
               waited < access_limit) begin
            @(negedge clk);
            if (use_fetch && fetch_done && f_cycles < 0) begin
                f_cycles = waited;
                check_value("fetch_inst", f_expect, fetch_inst);
            end
            if (use_data && data_done && d_cycles < 0) begin
                d_cycles = waited;
                if (!wr) begin
                    check_value("data_rdata", d_expect, data_rdata);
                end
            end
            next_cycle();
            waited++;
            // en drops on the cycle after its own done
            if (f_cycles >= 0) begin
                fetch_en = 1'b0;
            end
            if (d_cycles >= 0) begin
                data_en = 1'b0;
            end
        end
        fetch_en = 1'b0;
        data_en  = 1'b0;
        if ((use_fetch && f_cycles < 0) || (use_data && d_cycles < 0)) begin
            $display("timeout: no done within %0d cycles (fetch %h, data %h)",
                     access_limit, f_addr, addr);
            errors++;
        end else if (use_data && wr && addr[17:16] != io_map_pkg::io_region) begin
            model_write(addr, nbytes, wdata);
        end
    endtask

    task automatic fetch_burst(input int count, input bit check_latency);
        int f_cycles;
        int d_cycles;
        for (int i = 0; i < count; i++) begin
            run_access(1'b1, $urandom & 32'h0001_fffc, 1'b0, 1'b0, mem_pkg::len_byte,
                       '0, '0, f_cycles, d_cycles);
            if (check_latency) begin
                check_value("fetch_done latency", 32'(fetch_latency), 32'(f_cycles));
            end
        end
    endtask

    task automatic data_burst(input int count);
        logic          wr;
        mem_pkg::len_t len;
        logic [31:0]   addr;
        logic [31:0]   wdata;
        int            f_cycles;
        int            d_cycles;
        for (int i = 0; i < count; i++) begin
            wr    = ($urandom % 2) == 1;
            len   = pick_len();
            addr  = pick_addr(len);
            wdata = $urandom;
            run_access(1'b0, '0, 1'b1, wr, len, addr, wdata, f_cycles, d_cycles);
        end
    endtask

    task automatic idle_after_reset();
        int err_start;
        err_start = errors + bus_errors;
        repeat (4) begin
            next_cycle();
            @(negedge clk);
            check_value("mem_wr", 32'h0, 32'(mem_wr));
            check_value("fetch_done", 32'h0, 32'(fetch_done));
            check_value("data_done", 32'h0, 32'(data_done));
        end
        report_test("idle after reset", err_start);
    endtask

    task automatic both_clients();
        int            err_start;
        logic          wr;
        mem_pkg::len_t len;
        logic [31:0]   addr;
        logic [31:0]   f_addr;
        int            f_cycles;
        int            d_cycles;
        err_start = errors + bus_errors;
        for (int i = 0; i < 10; i++) begin
            // fetch stays below the store window
            f_addr = $urandom & 32'h0000_fffc;
            wr     = ($urandom % 2) == 1;
            len    = pick_len();
            addr   = 32'h0001_f000 | ($urandom & 32'h0000_003c);
            run_access(1'b1, f_addr, 1'b1, wr, len, addr, $urandom, f_cycles, d_cycles);
            checks++;
            if (d_cycles < 0 || f_cycles < 0 || d_cycles >= f_cycles) begin
                $display("data_done did not come before fetch_done (data %0d, fetch %0d)",
                         d_cycles, f_cycles);
                errors++;
            end
        end
        report_test("both clients at once", err_start);
    endtask

    task automatic uart_stores();
        int          err_start;
        logic [31:0] wdata;
        int          f_cycles;
        int          d_cycles;
        err_start  = errors + bus_errors;
        uart_waits = 0;
        full_random = 1'b1;
        repeat (20) begin
            wdata = $urandom;
            uart_expect.push_back(wdata[7:0]);
            run_access(1'b0, '0, 1'b1, 1'b1, mem_pkg::len_byte, io_map_pkg::io_uart_addr,
                       wdata, f_cycles, d_cycles);
        end
        full_random = 1'b0;
        check_value("uart_q size", 32'(uart_expect.size()), 32'(u_ram.uart_q.size()));
        for (int i = 0; i < uart_expect.size() && i < u_ram.uart_q.size(); i++) begin
            check_value("uart_q entry", 32'(uart_expect[i]), 32'(u_ram.uart_q[i]));
        end
        report_test($sformatf("UART stores (%0d stalled cycles)", uart_waits), err_start);
    endtask

    initial begin
        int err_start;
        void'($urandom(32'h00a29276));
        rst            = 1'b1;
        rdy            = 1'b1;
        fetch_en       = 1'b0;
        fetch_addr     = '0;
        data_en        = 1'b0;
        data_wr        = 1'b0;
        data_len       = mem_pkg::len_byte;
        data_addr      = '0;
        data_wdata     = '0;
        io_buffer_full = 1'b0;
        rdy_random     = 1'b0;
        full_random    = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        // model starts from the RAM preload
        for (int i = 0; i < ram_bytes; i++) begin
            model[17'(i)] = u_ram.mem[17'(i)];
        end

        idle_after_reset();

        err_start = errors + bus_errors;
        fetch_burst(100, 1'b1);
        report_test("fetch reads", err_start);

        err_start = errors + bus_errors;
        data_burst(150);
        report_test("loads and stores", err_start);

        both_clients();

        err_start = errors + bus_errors;
        frozen_cycles = 0;
        rdy_random = 1'b1;
        fetch_burst(50, 1'b0);
        data_burst(100);
        rdy_random = 1'b0;
        report_test($sformatf("rdy freeze (%0d frozen cycles)", frozen_cycles), err_start);

        uart_stores();

        $display("%0d checks, %0d errors", checks, errors + bus_errors);
        if (errors + bus_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== rv_memsys.f ====
logic/mem_pkg.sv
logic/io_map_pkg.sv
logic/mem_arbiter.sv
logic/byte_sequencer.sv
logic/memctrl.sv
tb/tb_ram.sv
tb/tb_memctrl.sv

// ==== Makefile ====
# build and run the memory controller testbench with Verilator

sim:
	verilator --binary --timing -j 0 --top-module tb_memctrl -f rv_memsys.f
	./obj_dir/Vtb_memctrl | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
